// ==== rtl/merge_sort_pkg.sv ====
/*
 * Shared constants and payload types for the two-way merge stage:
 * key and address widths, chunk length, loader and result words
 */

package merge_sort_pkg;

    // Width of one unsigned key
    localparam int key_width = 16;
    // Width of a key memory address
    localparam int addr_width = 8;

    typedef logic [key_width-1:0] key_t;
    typedef logic [addr_width-1:0] addr_t;

    // One extra bit so a chunk spanning the whole memory can be described
    typedef logic [addr_width:0] length_t;

    // Word pushed by a chunk loader into its buffer FIFO
    typedef struct packed {
        key_t key;
        logic last;
    } load_word_t;

    // Word pushed by the merger into the output FIFO.
    // Source is 0 for chunk A and 1 for chunk B
    typedef struct packed {
        key_t key;
        logic source;
        logic last;
    } result_word_t;

endpackage

// ==== rtl/key_memory.sv ====
/*
 * Key store with one host write port and two registered read ports
 */

`timescale 1ns/100ps

module key_memory import merge_sort_pkg::*; (
    input  logic  clock,
    // Host write port
    input  logic  load_enable,
    input  addr_t load_addr,
    input  key_t  load_key,
    // Read port used by the chunk A loader
    input  addr_t read_a_addr,
    output key_t  read_a_key,
    // Read port used by the chunk B loader
    input  addr_t read_b_addr,
    output key_t  read_b_key
);

    // One entry per address, so the whole address space is backed
    localparam int mem_depth = 2 ** addr_width;

    key_t storage [mem_depth];

    // Host writes land at the clock edge, one key per cycle
    always_ff @(posedge clock) begin
        if (load_enable) begin
            storage[load_addr] <= load_key;
        end
    end

    // Both read ports are registered.
    // Data appears exactly one cycle after the address is presented
    always_ff @(posedge clock) begin
        read_a_key <= storage[read_a_addr];
    end

    always_ff @(posedge clock) begin
        read_b_key <= storage[read_b_addr];
    end

    // A key written in the same cycle as it is read returns the old value,
    // which the host never relies on because loading finishes before start

endmodule

// ==== rtl/stream_fifo.sv ====
/*
 * Synchronous FIFO with a type-parameterized payload,
 * push/full on the write side and valid/ready on the read side
 */

`timescale 1ns/100ps

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int depth = 32
) (
    input  logic     clock,
    input  logic     reset,
    // Write side
    input  logic     push,
    input  payload_t push_word,
    output logic     full,
    // Read side
    output payload_t pop_word,
    output logic     pop_valid,
    input  logic     pop_ready
);

    // A single-entry FIFO still needs a one bit pointer
    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_width = $clog2(depth + 1);

    payload_t storage [depth];

    logic [ptr_width-1:0] write_ptr;
    logic [ptr_width-1:0] read_ptr;
    logic [count_width-1:0] count;

    logic do_push;
    logic do_pop;

    // Pointers wrap at depth, which need not be a power of two
    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        logic [ptr_width-1:0] last_index;
        last_index = ptr_width'(depth - 1);
        return (ptr == last_index) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == count_width'(depth));
    assign pop_valid = (count != '0);
    assign pop_word = storage[read_ptr];

    // A push into a full FIFO is dropped here and flagged below
    assign do_push = push && !full;
    assign do_pop = pop_valid && pop_ready;

    always_ff @(posedge clock) begin
        if (do_push) begin
            storage[write_ptr] <= push_word;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            write_ptr <= '0;
            read_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                write_ptr <= next_ptr(write_ptr);
            end
            if (do_pop) begin
                read_ptr <= next_ptr(read_ptr);
            end
            // Count only moves when exactly one side transfers
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // The producer must never overrun the buffer
    assert property (@(posedge clock) disable iff (reset) !(push && full))
        else $error("stream_fifo push while full");

endmodule

// ==== rtl/chunk_loader.sv ====
/*
 * Chunk loader FSM: reads one sorted chunk from the key memory and
 * pushes every key, with a last flag on the final one, into its FIFO
 */

`timescale 1ns/100ps

module chunk_loader import merge_sort_pkg::*; #(
    parameter int max_chunk_length = 32
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       start,
    input  addr_t      chunk_base,
    input  length_t    chunk_length,
    // Memory read port
    output addr_t      read_addr,
    input  key_t       read_key,
    // Buffer FIFO write side
    output logic       push,
    output load_word_t push_word
);

    typedef enum logic [1:0] {
        state_idle,
        state_wait,
        state_read,
        state_read_last
    } state_t;

    state_t state;

    // Keys still to be pushed, counting the one on read_key this cycle
    length_t keys_left;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= state_idle;
            read_addr <= '0;
            keys_left <= '0;
        end else begin
            case (state)
                state_idle: begin
                    // Start is ignored while a chunk is still being read
                    if (start) begin
                        read_addr <= chunk_base;
                        keys_left <= chunk_length;
                        state <= state_wait;
                    end
                end
                state_wait: begin
                    // The base address is in the memory this cycle,
                    // so its key returns in the next one
                    read_addr <= read_addr + 1'b1;
                    if (keys_left == length_t'(1)) begin
                        state <= state_read_last;
                    end else begin
                        state <= state_read;
                    end
                end
                state_read: begin
                    read_addr <= read_addr + 1'b1;
                    keys_left <= keys_left - 1'b1;
                    // Two left means the next returned key is the final one
                    if (keys_left == length_t'(2)) begin
                        state <= state_read_last;
                    end
                end
                state_read_last: begin
                    state <= state_idle;
                end
                default: begin
                    state <= state_idle;
                end
            endcase
        end
    end

    // Every key from the memory goes straight into the FIFO.
    // The chunk always fits, so full is never checked
    assign push = (state == state_read) || (state == state_read_last);
    assign push_word.key = read_key;
    assign push_word.last = (state == state_read_last);

    // Zero-length chunks are not supported
    assert property (@(posedge clock) disable iff (reset)
        (start && state == state_idle) |-> (chunk_length != '0))
        else $error("chunk_loader started with an empty chunk");

    // A longer chunk would overrun the buffer FIFO
    assert property (@(posedge clock) disable iff (reset)
        (start && state == state_idle) |-> (chunk_length <= length_t'(max_chunk_length)))
        else $error("chunk_loader chunk longer than the buffer FIFO");

endmodule

// ==== rtl/sorted_merger.sv ====
/*
 * Two-way merger: pops the smaller head of two sorted FIFOs and pushes
 * source-tagged keys into the output FIFO, then pulses done
 */

`timescale 1ns/100ps

module sorted_merger import merge_sort_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         start,
    // Chunk A buffer FIFO read side
    input  load_word_t   a_word,
    input  logic         a_valid,
    output logic         a_ready,
    // Chunk B buffer FIFO read side
    input  load_word_t   b_word,
    input  logic         b_valid,
    output logic         b_ready,
    // Output FIFO write side
    output logic         out_push,
    output result_word_t out_word,
    input  logic         out_full,
    // Last merged word accepted at the top-level output
    input  logic         result_last_taken,
    output logic         done
);

    // Set once the last key of a chunk has been popped.
    // Both are set while no merge is pending
    logic a_finished;
    logic b_finished;

    // High from start until the final word leaves the output FIFO
    logic merging;

    logic a_wins;
    logic take_a;
    logic take_b;

    // Ties go to A, which keeps the merge stable
    assign a_wins = (a_word.key <= b_word.key);

    // Take A when B is exhausted, or when both heads are present and A is
    // not larger. Waiting on a missing head avoids emitting out of order
    assign take_a = !out_full && !a_finished && a_valid &&
                    (b_finished || (b_valid && a_wins));

    // Take B under the mirrored conditions, with B strictly smaller
    assign take_b = !out_full && !b_finished && b_valid &&
                    (a_finished || (a_valid && !a_wins));

    assign a_ready = take_a;
    assign b_ready = take_b;

    assign out_push = take_a || take_b;
    assign out_word.key = take_b ? b_word.key : a_word.key;
    assign out_word.source = take_b;

    // The merged stream ends when a chunk's last key leaves
    // and the other chunk is already done
    assign out_word.last = (take_a && a_word.last && b_finished) ||
                           (take_b && b_word.last && a_finished);

    always_ff @(posedge clock) begin
        if (reset) begin
            a_finished <= 1'b1;
            b_finished <= 1'b1;
            merging <= 1'b0;
        end else if (start) begin
            a_finished <= 1'b0;
            b_finished <= 1'b0;
            merging <= 1'b1;
        end else begin
            if (take_a && a_word.last) begin
                a_finished <= 1'b1;
            end
            if (take_b && b_word.last) begin
                b_finished <= 1'b1;
            end
            if (done) begin
                merging <= 1'b0;
            end
        end
    end

    // One pulse per merge, in the cycle the host accepts the last word
    assign done = merging && result_last_taken;

    // Only one head may be consumed per decision
    assert property (@(posedge clock) disable iff (reset) !(a_ready && b_ready))
        else $error("sorted_merger popped both FIFOs in one cycle");

    // The last word can only reach the host after both chunks were consumed
    assert property (@(posedge clock) disable iff (reset)
        result_last_taken |-> (a_finished && b_finished))
        else $error("sorted_merger last result taken before both chunks ended");

endmodule

// ==== rtl/merge_sort_top.sv ====
/*
 * Merge stage top level: key memory, two chunk loaders with buffer FIFOs,
 * the merger, the output FIFO and the busy flag
 */

`timescale 1ns/100ps

module merge_sort_top import merge_sort_pkg::*; #(
    parameter int max_chunk_length = 32
) (
    input  logic    clock,
    input  logic    reset,
    // Host memory write
    input  logic    load_enable,
    input  addr_t   load_addr,
    input  key_t    load_key,
    // Merge control
    input  logic    start,
    input  addr_t   chunk_a_base,
    input  length_t chunk_a_length,
    input  addr_t   chunk_b_base,
    input  length_t chunk_b_length,
    // Result stream
    output key_t    result_key,
    output logic    result_source,
    output logic    result_last,
    output logic    result_valid,
    input  logic    result_ready,
    output logic    done,
    output logic    busy
);

    addr_t read_a_addr;
    addr_t read_b_addr;
    key_t read_a_key;
    key_t read_b_key;

    logic a_push;
    logic b_push;
    load_word_t a_push_word;
    load_word_t b_push_word;

    load_word_t a_word;
    load_word_t b_word;
    logic a_valid;
    logic b_valid;
    logic a_ready;
    logic b_ready;

    logic out_push;
    logic out_full;
    result_word_t out_word;
    result_word_t result_word;
    logic result_last_taken;

    key_memory keys (
        .clock(clock),
        .load_enable(load_enable),
        .load_addr(load_addr),
        .load_key(load_key),
        .read_a_addr(read_a_addr),
        .read_a_key(read_a_key),
        .read_b_addr(read_b_addr),
        .read_b_key(read_b_key)
    );

    chunk_loader #(.max_chunk_length(max_chunk_length)) loader_a (
        .clock(clock),
        .reset(reset),
        .start(start),
        .chunk_base(chunk_a_base),
        .chunk_length(chunk_a_length),
        .read_addr(read_a_addr),
        .read_key(read_a_key),
        .push(a_push),
        .push_word(a_push_word)
    );

    chunk_loader #(.max_chunk_length(max_chunk_length)) loader_b (
        .clock(clock),
        .reset(reset),
        .start(start),
        .chunk_base(chunk_b_base),
        .chunk_length(chunk_b_length),
        .read_addr(read_b_addr),
        .read_key(read_b_key),
        .push(b_push),
        .push_word(b_push_word)
    );

    // Loaders never look at full, since a chunk fits in its FIFO
    stream_fifo #(.payload_t(load_word_t), .depth(max_chunk_length)) fifo_a (
        .clock(clock),
        .reset(reset),
        .push(a_push),
        .push_word(a_push_word),
        .full(),
        .pop_word(a_word),
        .pop_valid(a_valid),
        .pop_ready(a_ready)
    );

    stream_fifo #(.payload_t(load_word_t), .depth(max_chunk_length)) fifo_b (
        .clock(clock),
        .reset(reset),
        .push(b_push),
        .push_word(b_push_word),
        .full(),
        .pop_word(b_word),
        .pop_valid(b_valid),
        .pop_ready(b_ready)
    );

    sorted_merger merger (
        .clock(clock),
        .reset(reset),
        .start(start),
        .a_word(a_word),
        .a_valid(a_valid),
        .a_ready(a_ready),
        .b_word(b_word),
        .b_valid(b_valid),
        .b_ready(b_ready),
        .out_push(out_push),
        .out_word(out_word),
        .out_full(out_full),
        .result_last_taken(result_last_taken),
        .done(done)
    );

    // Back-pressure from the host fills this FIFO and stalls the merger
    stream_fifo #(.payload_t(result_word_t), .depth(max_chunk_length)) fifo_out (
        .clock(clock),
        .reset(reset),
        .push(out_push),
        .push_word(out_word),
        .full(out_full),
        .pop_word(result_word),
        .pop_valid(result_valid),
        .pop_ready(result_ready)
    );

    assign result_key = result_word.key;
    assign result_source = result_word.source;
    assign result_last = result_word.last;

    // The final merged word is accepted by the host this cycle
    assign result_last_taken = result_valid && result_ready && result_word.last;

    // Busy rises the cycle after start and falls after the done pulse
    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

endmodule

// ==== verif/clock_gen.sv ====
/*
 * Testbench clock source with an 8 ns period and a synchronous
 * active-high reset held for the first 16 cycles
 */

`timescale 1ns/100ps

module clock_gen #(
    parameter int half_period = 4,
    parameter int reset_cycles = 16
) (
    output logic clock,
    output logic reset
);

    // Free-running clock, first rising edge at half_period
    initial begin
        clock = 1'b0;
        forever #(half_period) clock = ~clock;
    end

    // Reset drops on a rising edge so the DUT sees a clean release
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

// ==== verif/merge_sort_tb.sv ====
/*
 * Testbench for the merge stage: case table, memory loading, reference
 * merge, result checks under back-pressure, and a run watchdog
 */

`timescale 1ns/100ps

module merge_sort_tb import merge_sort_pkg::*; ();

    localparam int max_chunk_length = 32;
    localparam int num_cases = 6;
    localparam int ready_always = 0;
    localparam int ready_random = 1;
    localparam int ready_stalls = 2;

    // One column per field, one index per case.
    // Bases are nonzero where possible and the chunks never overlap
    localparam int a_base_table [num_cases] = '{0, 40, 100, 200, 5, 250};
    localparam int a_length_table [num_cases] = '{8, 1, 32, 12, 32, 3};
    localparam int b_base_table [num_cases] = '{16, 60, 140, 220, 50, 128};
    localparam int b_length_table [num_cases] = '{8, 32, 5, 12, 32, 1};
    localparam int seed_table [num_cases] = '{0, 3, 7, 11, 19, 23};
    localparam int ready_table [num_cases] = '{ready_always, ready_random, ready_stalls,
                                               ready_random, ready_stalls, ready_always};

    logic clock;
    logic reset;
    logic load_enable;
    addr_t load_addr;
    key_t load_key;
    logic start;
    addr_t chunk_a_base;
    length_t chunk_a_length;
    addr_t chunk_b_base;
    length_t chunk_b_length;
    key_t result_key;
    logic result_source;
    logic result_last;
    logic result_valid;
    logic result_ready;
    logic done;
    logic busy;

    logic [31:0] rng;
    key_t a_keys [max_chunk_length];
    key_t b_keys [max_chunk_length];

    // Reference merge of the current case
    key_t exp_key [2 * max_chunk_length];
    logic exp_source [2 * max_chunk_length];
    logic exp_last [2 * max_chunk_length];
    int exp_count;

    int error_count;
    int check_count;

    clock_gen clocks (
        .clock(clock),
        .reset(reset)
    );

    merge_sort_top #(.max_chunk_length(max_chunk_length)) UUT (
        .clock(clock),
        .reset(reset),
        .load_enable(load_enable),
        .load_addr(load_addr),
        .load_key(load_key),
        .start(start),
        .chunk_a_base(chunk_a_base),
        .chunk_a_length(chunk_a_length),
        .chunk_b_base(chunk_b_base),
        .chunk_b_length(chunk_b_length),
        .result_key(result_key),
        .result_source(result_source),
        .result_last(result_last),
        .result_valid(result_valid),
        .result_ready(result_ready),
        .done(done),
        .busy(busy)
    );

    // 32-bit xorshift, the only source of random keys and stalls
    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Twenty cycles per key covers loading and the slowest stall pattern
    function automatic int watchdog_cycles();
        int total;
        total = 0;
        for (int i = 0; i < num_cases; i++) begin
            total += a_length_table[i] + b_length_table[i];
        end
        return total * 20 + 300;
    endfunction

    // Ready for the next cycle under the case's back-pressure pattern
    function automatic logic next_ready(input int pattern, input int cycle);
        logic ready;
        case (pattern)
            ready_random: begin
                rng = xorshift32(rng);
                ready = rng[7];
            end
            // 40 stalled cycles out of 48 are enough to fill the output FIFO
            ready_stalls: ready = (cycle % 48) >= 40;
            default: ready = 1'b1;
        endcase
        return ready;
    endfunction

    // Outside a merge the result stream and the status outputs stay low
    task automatic check_idle(input string where);
        check_count++;
        if (result_valid || done || busy) begin
            $display("Mismatch at %0t: %s, valid %b done %b busy %b with no merge running",
                     $time, where, result_valid, done, busy);
            error_count++;
        end
    endtask

    task automatic write_key(input int addr, input key_t key);
        @(posedge clock);
        load_enable <= 1'b1;
        load_addr <= addr_t'(addr);
        load_key <= key;
        @(negedge clock);
        check_idle("while loading");
    endtask

    // Ascending keys, each one the previous plus a step of 0 to 3.
    // Both chunks start low, so their key ranges interleave and share values
    task automatic load_chunk(input int base, input int length, input bit chunk_b);
        key_t key;
        rng = xorshift32(rng);
        key = key_t'(rng[3:0]);
        for (int i = 0; i < length; i++) begin
            if (i > 0) begin
                rng = xorshift32(rng);
                key = key + key_t'(rng[1:0]);
            end
            if (chunk_b) begin
                b_keys[i] = key;
            end else begin
                a_keys[i] = key;
            end
            write_key(base + i, key);
        end
    endtask

    // Stable two-way merge, A first on equal keys, last flag on the final word
    task automatic build_expected(input int a_length, input int b_length);
        int ia;
        int ib;
        ia = 0;
        ib = 0;
        exp_count = 0;
        while (ia < a_length || ib < b_length) begin
            if (ib >= b_length || (ia < a_length && a_keys[ia] <= b_keys[ib])) begin
                exp_key[exp_count] = a_keys[ia];
                exp_source[exp_count] = 1'b0;
                ia++;
            end else begin
                exp_key[exp_count] = b_keys[ib];
                exp_source[exp_count] = 1'b1;
                ib++;
            end
            exp_last[exp_count] = 1'b0;
            exp_count++;
        end
        exp_last[exp_count - 1] = 1'b1;
    endtask

    task automatic check_result(input int index, input int position, input key_t previous);
        check_count++;
        if (position >= exp_count) begin
            $display("Case %0d produced more than the %0d expected words", index, exp_count);
            error_count++;
        end else if (result_key != exp_key[position] ||
                     result_source != exp_source[position] ||
                     result_last != exp_last[position]) begin
            $display("Mismatch at %0t: case %0d word %0d got key %h source %b last %b, %s",
                     $time, index, position, result_key, result_source, result_last,
                     $sformatf("expected key %h source %b last %b", exp_key[position],
                               exp_source[position], exp_last[position]));
            error_count++;
        end
        check_count++;
        if (position > 0 && result_key < previous) begin
            $display("Mismatch at %0t: case %0d word %0d key %h below previous key %h",
                     $time, index, position, result_key, previous);
            error_count++;
        end
    endtask

    // Strobe start, then collect every accepted word until done
    task automatic run_merge(input int index);
        int got;
        int cycle;
        bit finished;
        bit last_accepted;
        key_t previous;
        got = 0;
        cycle = 0;
        finished = 1'b0;
        previous = '0;
        @(posedge clock);
        load_enable <= 1'b0;
        chunk_a_base <= addr_t'(a_base_table[index]);
        chunk_a_length <= length_t'(a_length_table[index]);
        chunk_b_base <= addr_t'(b_base_table[index]);
        chunk_b_length <= length_t'(b_length_table[index]);
        start <= 1'b1;
        @(negedge clock);
        // Busy only rises on the edge that samples start
        check_idle("in the start cycle");
        while (!finished) begin
            @(posedge clock);
            start <= 1'b0;
            result_ready <= next_ready(ready_table[index], cycle);
            cycle++;
            @(negedge clock);
            check_count++;
            if (!busy) begin
                $display("Mismatch at %0t: busy low while case %0d is merging", $time, index);
                error_count++;
            end
            last_accepted = 1'b0;
            if (result_valid && result_ready) begin
                check_result(index, got, previous);
                previous = result_key;
                got++;
                last_accepted = (got == exp_count);
            end
            // Done belongs to the cycle where the final expected word is accepted
            check_count++;
            if (done != last_accepted) begin
                $display("Mismatch at %0t: case %0d done %b while final word taken is %b",
                         $time, index, done, last_accepted);
                error_count++;
            end
            if (done) begin
                finished = 1'b1;
            end
        end
        check_count++;
        if (got != exp_count) begin
            $display("Mismatch at %0t: case %0d delivered %0d words, expected %0d",
                     $time, index, got, exp_count);
            error_count++;
        end
        // One cycle later busy has dropped and the output FIFO is empty
        @(posedge clock);
        result_ready <= 1'b1;
        @(negedge clock);
        check_idle("after done");
    endtask

    initial begin
        int errors_before;
        load_enable = 1'b0;
        load_addr = '0;
        load_key = '0;
        start = 1'b0;
        chunk_a_base = '0;
        chunk_a_length = '0;
        chunk_b_base = '0;
        chunk_b_length = '0;
        result_ready = 1'b0;
        rng = 32'h88f;
        error_count = 0;
        check_count = 0;
        exp_count = 0;
        wait (reset == 1'b0);
        for (int i = 0; i < num_cases; i++) begin
            errors_before = error_count;
            rng = 32'h88f + seed_table[i];
            load_chunk(a_base_table[i], a_length_table[i], 1'b0);
            load_chunk(b_base_table[i], b_length_table[i], 1'b1);
            build_expected(a_length_table[i], b_length_table[i]);
            run_merge(i);
            $display("Case %0d: A %0d keys at %0d, B %0d keys at %0d, pattern %0d, %0d errors",
                     i, a_length_table[i], a_base_table[i], b_length_table[i],
                     b_base_table[i], ready_table[i], error_count - errors_before);
        end
        $display("Cases %0d, checks %0d, errors %0d", num_cases, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Ends a run whose merge never completes
    initial begin
        int limit;
        limit = watchdog_cycles();
        repeat (limit) @(posedge clock);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/merge_sort_pkg.sv
rtl/key_memory.sv
rtl/stream_fifo.sv
rtl/chunk_loader.sv
rtl/sorted_merger.sv
rtl/merge_sort_top.sv
verif/clock_gen.sv
verif/merge_sort_tb.sv

// ==== Makefile ====
# Verilator flow for the merge stage: lint, simulate, clean

VERILATOR ?= verilator
TOP ?= merge_sort_tb
RTL_TOP ?= merge_sort_top
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
PASS_TEXT ?= TEST PASS

SOURCES := $(shell cat $(FLIST))
RTL_FILES := $(filter rtl/%,$(SOURCES))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# The run passes only if the pass line appears in the output
sim: $(BUILD_DIR)/V$(TOP)
	@output="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
